/* design/u2_ctrl_settings.svh */
/*
 * Setting bus addresses, readback word indices and fixed constants of the
 * control core. Include wherever a block decodes writes or builds readback.
 */
`ifndef U2_CTRL_SETTINGS_SVH
`define U2_CTRL_SETTINGS_SVH

// Misc register bank
`define SR_MISC          8'd0
`define SR_SERDES        (`SR_MISC + 8'd1)
`define SR_ADC           (`SR_MISC + 8'd2)
`define SR_LED_SW        (`SR_MISC + 8'd3)
`define SR_PHY           (`SR_MISC + 8'd4)
`define SR_LED_SRC       (`SR_MISC + 8'd6)

// VITA time registers
// Control bit 0 set loads at once
`define SR_TIME64        8'd10
`define SR_TIME_HI       (`SR_TIME64 + 8'd0)
`define SR_TIME_LO       (`SR_TIME64 + 8'd1)
`define SR_TIME_CTRL     (`SR_TIME64 + 8'd2)

// LEDs 1 to 4 start under hardware control
`define LED_SRC_RESET    8'h1E

// Major 8, minor 3
`define COMPAT_NUM       {16'd8, 16'd3}

// Readback word indices
`define RB_COMPAT        4'd0
`define RB_TIME_HI       4'd1
`define RB_TIME_LO       4'd2
`define RB_PPS_HI        4'd3
`define RB_PPS_LO        4'd4
`define RB_STATUS        4'd5

`endif

/* design/u2_ctrl_pkg.sv */
/*
 * Shared types of the control core: vector widths and the settings bus.
 * Modules pull these in with a wildcard import in their header.
 */
`default_nettype none

package u2_ctrl_pkg;

   ////////////////////////////////////////////////////////////
   // Plain vector types
   ////////////////////////////////////////////////////////////

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [63:0] vita_time_t;
   typedef logic [7:0]  ctrl_byte_t;
   typedef logic [3:0]  rb_addr_t;
   typedef logic [31:0] rb_word_t;

   ////////////////////////////////////////////////////////////
   // Settings bus
   ////////////////////////////////////////////////////////////

   // One-cycle write strobe with no back-pressure
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

endpackage

`default_nettype wire

/* design/set_bus_stage.sv */
/*
 * Input register for host setting writes. Drives the internal settings
 * bus that all register consumers decode in parallel.
 */
`timescale 1ns/1ps
`default_nettype none

module set_bus_stage import u2_ctrl_pkg::*; (
   input  wire       dsp_clk,
   input  wire       rst_n_i,
   input  wire       set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   output set_bus_t  set_bus_o
);

   // Host write enters the settings bus
   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         set_bus_o <= '0;
      end else begin
         set_bus_o.stb  <= set_stb_i;
         set_bus_o.addr <= set_addr_i;
         set_bus_o.data <= set_data_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // A host write must carry a known address and word
   a_write_known: assert property (
      @(posedge dsp_clk) disable iff (!rst_n_i)
      set_stb_i |-> !$isunknown({set_addr_i, set_data_i})
   ) else $error("set bus write with unknown address or data");

endmodule

`default_nettype wire

/* design/misc_regs.sv */
/*
 * Misc control bank: SERDES, ADC, PHY reset and LED registers.
 * LEDs pick hardware or software values per bit from the LED source register.
 */
`timescale 1ns/1ps
`default_nettype none

`include "u2_ctrl_settings.svh"

module misc_regs import u2_ctrl_pkg::*; (
   input  wire        dsp_clk,
   input  wire        rst_n_i,
   input  set_bus_t   set_bus_i,
   input  wire        good_sync_i,
   input  wire        run_rx_i,
   input  wire        run_tx_i,
   input  wire        clk_status_i,
   output ctrl_byte_t serdes_ctrl_o,
   output ctrl_byte_t adc_ctrl_o,
   output ctrl_byte_t leds_o,
   output logic       phy_resetn_o
);

   ctrl_byte_t led_sw;
   ctrl_byte_t led_src;
   ctrl_byte_t led_hw;
   logic       phy_reset;

   ////////////////////////////////////////////////////////////
   // Register decode
   ////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         serdes_ctrl_o <= '0;
         adc_ctrl_o    <= '0;
         led_sw        <= '0;
         led_src       <= `LED_SRC_RESET;
         phy_reset     <= 1'b0;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            `SR_SERDES:  serdes_ctrl_o <= set_bus_i.data[7:0];
            `SR_ADC:     adc_ctrl_o    <= set_bus_i.data[7:0];
            `SR_LED_SW:  led_sw        <= set_bus_i.data[7:0];
            `SR_PHY:     phy_reset     <= set_bus_i.data[0];
            `SR_LED_SRC: led_src       <= set_bus_i.data[7:0];
            default: ;
         endcase
      end
   end

   // PHY reset pin is active low
   assign phy_resetn_o = ~phy_reset;

   ////////////////////////////////////////////////////////////
   // LED source select
   ////////////////////////////////////////////////////////////

   // Hardware status byte
   // LED 0 and the top three bits have no hardware source
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, good_sync_i, 1'b0};

   // 1 selects hardware, 0 selects software
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   a_led_src_reset: assert property (
      @(posedge dsp_clk)
      $rose(rst_n_i) |-> (led_src == `LED_SRC_RESET)
   ) else $error("LED source register missed its reset value");

endmodule

`default_nettype wire

/* design/vita_time.sv */
/*
 * 64-bit VITA time counter with PPS capture. Time loads from the pending
 * words either at once or at the next synchronized PPS edge.
 */
`timescale 1ns/1ps
`default_nettype none

`include "u2_ctrl_settings.svh"

module vita_time import u2_ctrl_pkg::*; (
   input  wire        dsp_clk,
   input  wire        rst_n_i,
   input  set_bus_t   set_bus_i,
   input  wire        pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       good_sync_o
);

   logic       pps_meta;
   logic       pps_sync;
   logic       pps_dly;
   logic       pps_edge;
   set_data_t  pend_hi;
   set_data_t  pend_lo;
   logic       armed;
   logic       ctrl_wr;
   logic       load_now;
   logic       pps_load;
   logic       time_load;
   vita_time_t time_next;

   ////////////////////////////////////////////////////////////
   // PPS synchronizer and rising edge
   ////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_dly  <= 1'b0;
      end else begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_dly  <= pps_sync;
      end
   end

   assign pps_edge = pps_sync & ~pps_dly;

   ////////////////////////////////////////////////////////////
   // Pending time and load control
   ////////////////////////////////////////////////////////////

   assign ctrl_wr   = set_bus_i.stb && (set_bus_i.addr == `SR_TIME_CTRL);
   assign load_now  = ctrl_wr && set_bus_i.data[0];
   assign pps_load  = pps_edge && armed;
   assign time_load = load_now || pps_load;
   assign time_next = time_load ? {pend_hi, pend_lo} : vita_time_o + 64'd1;

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         pend_hi     <= '0;
         pend_lo     <= '0;
         armed       <= 1'b0;
         good_sync_o <= 1'b0;
      end else begin
         if (set_bus_i.stb && (set_bus_i.addr == `SR_TIME_HI))
            pend_hi <= set_bus_i.data;
         if (set_bus_i.stb && (set_bus_i.addr == `SR_TIME_LO))
            pend_lo <= set_bus_i.data;
         if (pps_load) begin
            armed       <= 1'b0;
            good_sync_o <= 1'b1;
         end
         // A new arm request wins over a load in the same cycle
         if (ctrl_wr && !set_bus_i.data[0])
            armed <= 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Counter and PPS capture
   ////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
      end else begin
         vita_time_o <= time_next;
         // Capture is the value the counter takes at this PPS edge
         if (pps_edge)
            vita_time_pps_o <= time_next;
      end
   end

   a_time_step: assert property (
      @(posedge dsp_clk) disable iff (!rst_n_i)
      ($past(rst_n_i) && !$past(time_load)) |-> (vita_time_o == $past(vita_time_o) + 64'd1)
   ) else $error("VITA time did not advance by one");

endmodule

`default_nettype wire

/* design/readback_mux.sv */
/*
 * Registered readback of 16 words selected by index. Output shows the
 * addressed word one cycle after the index is sampled.
 */
`timescale 1ns/1ps
`default_nettype none

`include "u2_ctrl_settings.svh"

module readback_mux import u2_ctrl_pkg::*; (
   input  wire        dsp_clk,
   input  wire        rst_n_i,
   input  rb_addr_t   rb_addr_i,
   input  vita_time_t vita_time_i,
   input  vita_time_t vita_time_pps_i,
   input  wire        good_sync_i,
   input  wire        clk_status_i,
   output rb_word_t   rb_data_o
);

   rb_word_t status_word;

   // Clock status above sync flag
   assign status_word = {30'd0, clk_status_i, good_sync_i};

   ////////////////////////////////////////////////////////////
   // Word select
   ////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         rb_data_o <= '0;
      end else begin
         case (rb_addr_i)
            `RB_COMPAT:  rb_data_o <= `COMPAT_NUM;
            `RB_TIME_HI: rb_data_o <= vita_time_i[63:32];
            `RB_TIME_LO: rb_data_o <= vita_time_i[31:0];
            `RB_PPS_HI:  rb_data_o <= vita_time_pps_i[63:32];
            `RB_PPS_LO:  rb_data_o <= vita_time_pps_i[31:0];
            `RB_STATUS:  rb_data_o <= status_word;
            // Spare words
            default:     rb_data_o <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/u2_ctrl_top.sv */
/*
 * Top level of the control core. Host setting writes in, control lines
 * and the readback word out.
 */
`timescale 1ns/1ps
`default_nettype none

module u2_ctrl_top import u2_ctrl_pkg::*; (
   input  wire        dsp_clk,
   input  wire        rst_n_i,
   input  wire        set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  rb_addr_t   rb_addr_i,
   input  wire        pps_i,
   input  wire        run_rx_i,
   input  wire        run_tx_i,
   input  wire        clk_status_i,
   output ctrl_byte_t serdes_ctrl_o,
   output ctrl_byte_t adc_ctrl_o,
   output ctrl_byte_t leds_o,
   output logic       phy_resetn_o,
   output rb_word_t   rb_data_o
);

   set_bus_t   set_bus;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;
   logic       good_sync;

   ////////////////////////////////////////////////////////////
   // Settings bus
   ////////////////////////////////////////////////////////////

   set_bus_stage i_set_bus_stage (
      .dsp_clk    (dsp_clk),
      .rst_n_i    (rst_n_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .set_bus_o  (set_bus)
   );

   ////////////////////////////////////////////////////////////
   // Consumers
   ////////////////////////////////////////////////////////////

   misc_regs i_misc_regs (
      .dsp_clk       (dsp_clk),
      .rst_n_i       (rst_n_i),
      .set_bus_i     (set_bus),
      .good_sync_i   (good_sync),
      .run_rx_i      (run_rx_i),
      .run_tx_i      (run_tx_i),
      .clk_status_i  (clk_status_i),
      .serdes_ctrl_o (serdes_ctrl_o),
      .adc_ctrl_o    (adc_ctrl_o),
      .leds_o        (leds_o),
      .phy_resetn_o  (phy_resetn_o)
   );

   vita_time i_vita_time (
      .dsp_clk         (dsp_clk),
      .rst_n_i         (rst_n_i),
      .set_bus_i       (set_bus),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps),
      .good_sync_o     (good_sync)
   );

   // Readback
   readback_mux i_readback_mux (
      .dsp_clk         (dsp_clk),
      .rst_n_i         (rst_n_i),
      .rb_addr_i       (rb_addr_i),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps),
      .good_sync_i     (good_sync),
      .clk_status_i    (clk_status_i),
      .rb_data_o       (rb_data_o)
   );

endmodule

`default_nettype wire

/* testbench/tb_u2_ctrl_checks.svh */
/*
 * Typed compare tasks and error counters for the control core testbench.
 * Included inside the testbench top module, after the package import.
 */
`ifndef TB_U2_CTRL_CHECKS_SVH
`define TB_U2_CTRL_CHECKS_SVH

int check_count = 0;
int error_count = 0;

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

// Control register bytes and LEDs
task automatic check_byte(input ctrl_byte_t got, input ctrl_byte_t exp, input string what);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t: %s got 8'h%02h expected 8'h%02h", $time, what, got, exp);
   end
endtask

// Readback words
task automatic check_word(input rb_word_t got, input rb_word_t exp, input string what);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t: %s got 32'h%08h expected 32'h%08h", $time, what, got, exp);
   end
endtask

// Single bits and window conditions
task automatic check_bit(input logic got, input logic exp, input string what);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
   end
endtask

`endif

/* testbench/tb_u2_ctrl_top.sv */
/*
 * Directed testbench for the control core. Drives setting writes and
 * readback reads, then checks control outputs, LEDs and VITA time.
 */
`timescale 1ns/1ps
`default_nettype none

`include "u2_ctrl_settings.svh"

module tb_u2_ctrl_top import u2_ctrl_pkg::*; ();

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 8;
   // Rough cycle budget of each test
   localparam int T_RESET_VALUES = 12;
   localparam int T_MISC         = 30;
   localparam int T_LED          = 24;
   localparam int T_LOAD         = 30;
   localparam int T_PPS          = 110;
   localparam int T_MARGIN       = 100;
   localparam int WATCHDOG_NS    = (RESET_CYCLES + T_RESET_VALUES + T_MISC + T_LED
                                    + T_LOAD + T_PPS + T_MARGIN) * CLK_PERIOD;

   logic       dsp_clk;
   logic       rst_n_i;
   logic       set_stb_i;
   set_addr_t  set_addr_i;
   set_data_t  set_data_i;
   rb_addr_t   rb_addr_i;
   logic       pps_i;
   logic       run_rx_i;
   logic       run_tx_i;
   logic       clk_status_i;
   ctrl_byte_t serdes_ctrl_o;
   ctrl_byte_t adc_ctrl_o;
   ctrl_byte_t leds_o;
   logic       phy_resetn_o;
   rb_word_t   rb_data_o;

   int seed = 32'h613f8df3;

   // Expected LED register contents and sync state
   ctrl_byte_t exp_led_sw;
   ctrl_byte_t exp_led_src;
   logic       exp_sync;

   `include "tb_u2_ctrl_checks.svh"

   u2_ctrl_top i_u2_ctrl_top (
      .dsp_clk       (dsp_clk),
      .rst_n_i       (rst_n_i),
      .set_stb_i     (set_stb_i),
      .set_addr_i    (set_addr_i),
      .set_data_i    (set_data_i),
      .rb_addr_i     (rb_addr_i),
      .pps_i         (pps_i),
      .run_rx_i      (run_rx_i),
      .run_tx_i      (run_tx_i),
      .clk_status_i  (clk_status_i),
      .serdes_ctrl_o (serdes_ctrl_o),
      .adc_ctrl_o    (adc_ctrl_o),
      .leds_o        (leds_o),
      .phy_resetn_o  (phy_resetn_o),
      .rb_data_o     (rb_data_o)
   );

   initial dsp_clk = 1'b0;
   always #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;

   ////////////////////////////////////////////////////////////
   // Bus helpers and reference model
   ////////////////////////////////////////////////////////////

   function automatic set_data_t next_rand();
      return $random(seed);
   endfunction

   // One-cycle strobe driven on the falling edge
   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      @(negedge dsp_clk);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(negedge dsp_clk);
      set_stb_i = 1'b0;
   endtask

   // Word is registered one edge after the index is sampled
   task automatic read_word(input rb_addr_t idx, output rb_word_t word);
      @(negedge dsp_clk);
      rb_addr_i = idx;
      @(negedge dsp_clk);
      word = rb_data_o;
   endtask

   // Per-bit choice between hardware status and software byte
   function automatic ctrl_byte_t expected_leds();
      ctrl_byte_t hw;
      ctrl_byte_t result;
      hw    = 8'h00;
      hw[4] = run_tx_i;
      hw[3] = run_rx_i;
      hw[2] = clk_status_i;
      hw[1] = exp_sync;
      for (int b = 0; b < 8; b++) begin
         result[b] = exp_led_src[b] ? hw[b] : exp_led_sw[b];
      end
      return result;
   endfunction

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////

   task automatic test_reset_values();
      rb_word_t word;
      check_byte(leds_o, expected_leds(), "LEDs after reset");
      check_bit(phy_resetn_o, 1'b1, "PHY reset pin after reset");
      read_word(`RB_COMPAT, word);
      check_word(word, `COMPAT_NUM, "compatibility number");
      read_word(`RB_STATUS, word);
      check_bit(word[0], 1'b0, "good_sync after reset");
      check_bit(word[1], clk_status_i, "clk_status in status word");
   endtask

   task automatic test_misc_regs();
      set_data_t serdes_val;
      set_data_t adc_val;
      set_data_t phy_val;
      serdes_val = next_rand();
      adc_val    = next_rand();
      // Bit 0 set moves the PHY pin away from its reset level
      phy_val    = next_rand() | 32'h0000_0001;
      write_setting(`SR_MISC + 8'd1, serdes_val);
      write_setting(`SR_MISC + 8'd2, adc_val);
      write_setting(`SR_MISC + 8'd4, phy_val);
      repeat (2) @(negedge dsp_clk);
      check_byte(serdes_ctrl_o, serdes_val[7:0], "SERDES control");
      check_byte(adc_ctrl_o, adc_val[7:0], "ADC control");
      check_bit(phy_resetn_o, ~phy_val[0], "PHY reset pin");
      // Offset 5 is not decoded
      write_setting(`SR_MISC + 8'd5, next_rand());
      repeat (2) @(negedge dsp_clk);
      check_byte(serdes_ctrl_o, serdes_val[7:0], "SERDES after unused write");
      check_byte(adc_ctrl_o, adc_val[7:0], "ADC after unused write");
      check_bit(phy_resetn_o, ~phy_val[0], "PHY pin after unused write");
      check_byte(leds_o, expected_leds(), "LEDs after unused write");
   endtask

   task automatic test_led_mux();
      set_data_t sw_word;
      set_data_t src_word;
      set_data_t bits;
      sw_word  = next_rand();
      src_word = next_rand();
      write_setting(`SR_MISC + 8'd3, sw_word);
      write_setting(`SR_MISC + 8'd6, src_word);
      exp_led_sw  = sw_word[7:0];
      exp_led_src = src_word[7:0];
      repeat (2) @(negedge dsp_clk);
      check_byte(leds_o, expected_leds(), "LEDs after source write");
      for (int i = 0; i < 6; i++) begin
         bits         = next_rand();
         run_tx_i     = bits[0];
         run_rx_i     = bits[1];
         clk_status_i = bits[2];
         @(negedge dsp_clk);
         check_byte(leds_o, expected_leds(), "LEDs with varied status inputs");
      end
   endtask

   task automatic test_time_load();
      set_data_t hi_val;
      set_data_t lo_val;
      rb_word_t  hi_first;
      rb_word_t  lo_first;
      rb_word_t  lo_second;
      rb_word_t  hi_second;
      hi_val = next_rand();
      // Top bit clear keeps the low word far from overflow
      lo_val = next_rand() & 32'h7fff_ffff;
      write_setting(`SR_TIME64 + 8'd0, hi_val);
      write_setting(`SR_TIME64 + 8'd1, lo_val);
      write_setting(`SR_TIME64 + 8'd2, 32'h0000_0001);
      read_word(`RB_TIME_HI, hi_first);
      read_word(`RB_TIME_LO, lo_first);
      read_word(`RB_TIME_LO, lo_second);
      read_word(`RB_TIME_HI, hi_second);
      check_word(hi_first, hi_val, "time high word after load");
      check_word(hi_second, hi_val, "time high word on second read");
      check_bit((lo_first >= lo_val) && ((lo_first - lo_val) <= 32'd64), 1'b1,
                "time low word within 64 of load");
      check_bit(lo_second > lo_first, 1'b1, "time low word advancing");
   endtask

   task automatic test_pps_load();
      set_data_t hi_val;
      set_data_t lo_val;
      rb_word_t  word;
      logic      found;
      int        polls;
      hi_val = next_rand();
      lo_val = next_rand() & 32'h7fff_ffff;
      write_setting(`SR_TIME64 + 8'd0, hi_val);
      write_setting(`SR_TIME64 + 8'd1, lo_val);
      write_setting(`SR_TIME64 + 8'd2, 32'h0000_0000);
      @(negedge dsp_clk);
      pps_i = 1'b1;
      repeat (4) @(negedge dsp_clk);
      pps_i = 1'b0;
      // Wait for the timed load to report sync
      found = 1'b0;
      polls = 0;
      while (!found && polls < 40) begin
         read_word(`RB_STATUS, word);
         found = word[0];
         polls++;
      end
      if (!found) begin
         error_count++;
         $display("good_sync did not rise within 40 status reads after the PPS pulse");
      end
      exp_sync = 1'b1;
      check_bit(word[1], clk_status_i, "clk_status in status word");
      read_word(`RB_PPS_HI, word);
      check_word(word, hi_val, "PPS captured high word");
      read_word(`RB_PPS_LO, word);
      check_bit((word >= lo_val) && ((word - lo_val) <= 32'd16), 1'b1,
                "PPS captured low word within 16 of pending");
      read_word(`RB_TIME_HI, word);
      check_word(word, hi_val, "time high word after PPS load");
      check_byte(leds_o, expected_leds(), "LEDs with good_sync set");
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////////////////////////

   initial begin
      rst_n_i      = 1'b0;
      set_stb_i    = 1'b0;
      set_addr_i   = '0;
      set_data_i   = '0;
      rb_addr_i    = '0;
      pps_i        = 1'b0;
      run_rx_i     = 1'b1;
      run_tx_i     = 1'b0;
      clk_status_i = 1'b1;
      exp_led_sw   = 8'h00;
      exp_led_src  = `LED_SRC_RESET;
      exp_sync     = 1'b0;
      repeat (RESET_CYCLES) @(negedge dsp_clk);
      rst_n_i = 1'b1;
      @(negedge dsp_clk);

      test_reset_values();
      test_misc_regs();
      test_led_mux();
      test_time_load();
      test_pps_load();

      $display("Summary: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
+incdir+design
+incdir+testbench
design/u2_ctrl_pkg.sv
design/set_bus_stage.sv
design/misc_regs.sv
design/vita_time.sv
design/readback_mux.sv
design/u2_ctrl_top.sv
testbench/tb_u2_ctrl_top.sv

/* Makefile */
# Verilator lint and simulation of the u2 control core

VERILATOR  ?= verilator
FLIST      ?= flist.f
RTL_TOP    ?= u2_ctrl_top
TB_TOP     ?= tb_u2_ctrl_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
FAIL_MSG   ?= Simulation FAILED
PASS_MSG   ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Failure found in $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run ended without a result line"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
